/* gjPkg.sv */
package gjPkg;

    // Width of one matrix element
    parameter int elemWidth = 32;

    // Row and column index width, enough for 8 rows and 16 augmented columns
    parameter int idxWidth = 4;

    // Signed element, products wrap at this width
    typedef logic signed [elemWidth-1:0] elem_t;

    typedef logic [idxWidth-1:0] idx_t;

    // Sequencer states
    typedef enum logic [2:0]
    {
        stIdle,
        stFill,
        stSearch,
        stSwap,
        stEliminate,
        stNextCol,
        stDone,
        stSingular
    } gjState_t;

endpackage

/* matrixStore.sv */
`timescale 1ns/1ps

module matrixStore import gjPkg::*;
#(
    parameter int matrixSize = 4
)
(
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              busy,
    input  logic                              wrEn,
    input  idx_t                              wrRow,
    input  idx_t                              wrCol,
    input  elem_t                             wrData,
    input  logic                              fillEn,
    input  logic                              swapEn,
    input  idx_t                              swapA,
    input  idx_t                              swapB,
    input  logic                              writeEn,
    input  idx_t                              targetRow,
    input  idx_t                              pivotRow,
    input  idx_t                              pivotCol,
    input  logic [2*matrixSize*elemWidth-1:0] newRow,
    input  logic                              skip,
    input  idx_t                              rdRow,
    input  idx_t                              rdCol,
    output logic [2*matrixSize*elemWidth-1:0] targetVec,
    output logic [2*matrixSize*elemWidth-1:0] pivotVec,
    output elem_t                             searchElem,
    output elem_t                             pivotElem,
    output elem_t                             rdElem
);

    localparam int augWidth = 2 * matrixSize;

    typedef logic [augWidth*elemWidth-1:0] rowVec_t;

    // Augmented matrix, left half from the host and right half the identity
    elem_t mem [matrixSize][augWidth];

    rowVec_t swapAVec;
    rowVec_t swapBVec;
    rowVec_t rdVec;
    logic    wrAccept;
    logic    rowWrite;

    function automatic rowVec_t rowSel(idx_t sel);
        rowVec_t v;
        v = '0;
        for (int r = 0; r < matrixSize; r++)
        begin
            if (idx_t'(r) == sel)
            begin
                for (int c = 0; c < augWidth; c++)
                    v[c*elemWidth +: elemWidth] = mem[r][c];
            end
        end
        return v;
    endfunction

    function automatic elem_t elemSel(rowVec_t v, idx_t sel);
        elem_t e;
        e = '0;
        for (int c = 0; c < augWidth; c++)
        begin
            if (idx_t'(c) == sel)
                e = v[c*elemWidth +: elemWidth];
        end
        return e;
    endfunction

    always_comb
    begin
        targetVec = rowSel(targetRow);
        pivotVec = rowSel(pivotRow);
        swapAVec = rowSel(swapA);
        swapBVec = rowSel(swapB);
        rdVec = rowSel(rdRow);
        searchElem = elemSel(targetVec, pivotCol);
        pivotElem = elemSel(pivotVec, pivotCol);
        rdElem = elemSel(rdVec, rdCol);
    end

    // Host writes only land while the sequencer sits idle
    assign wrAccept = wrEn && !busy && !rst;
    assign rowWrite = writeEn && !skip;

    always_ff @(posedge clk)
    begin
        for (int r = 0; r < matrixSize; r++)
        begin
            for (int c = 0; c < augWidth; c++)
            begin
                if (fillEn && c >= matrixSize)
                    mem[r][c] <= (c == r + matrixSize) ? elem_t'(1) : elem_t'(0);
                else if (swapEn && idx_t'(r) == swapA)
                    mem[r][c] <= swapBVec[c*elemWidth +: elemWidth];
                else if (swapEn && idx_t'(r) == swapB)
                    mem[r][c] <= swapAVec[c*elemWidth +: elemWidth];
                else if (rowWrite && idx_t'(r) == targetRow)
                    mem[r][c] <= newRow[c*elemWidth +: elemWidth];
                else if (wrAccept && c < matrixSize && idx_t'(r) == wrRow && idx_t'(c) == wrCol)
                    mem[r][c] <= wrData;
            end
        end
    end

    // Accepted host writes never meet an engine update
    hostWriteIdle: assert property (@(posedge clk) disable iff (rst)
        wrAccept |-> !(fillEn || swapEn || writeEn))
        else $error("host write overlaps an engine update");

endmodule

/* pivotDecode.sv */
`timescale 1ns/1ps

module pivotDecode import gjPkg::*;
#(
    parameter int matrixSize = 4
)
(
    input  logic  clk,
    input  logic  rst,
    input  logic  start,
    input  elem_t searchElem,
    input  elem_t pivotElem,
    output logic  fillEn,
    output logic  swapEn,
    output idx_t  swapA,
    output idx_t  swapB,
    output logic  writeEn,
    output idx_t  targetRow,
    output idx_t  pivotRow,
    output idx_t  pivotCol,
    output logic  busy,
    output logic  finished,
    output logic  singular
);

    localparam idx_t lastRow = idx_t'(matrixSize - 1);

    gjState_t state;
    idx_t     col;
    idx_t     rowPtr;
    idx_t     firstRow;
    idx_t     nextElim;

    // First row to eliminate, and the one after rowPtr, both skip the pivot row
    always_comb
    begin
        firstRow = (col == '0) ? idx_t'(1) : idx_t'(0);
        if (idx_t'(rowPtr + idx_t'(1)) == col)
            nextElim = idx_t'(rowPtr + idx_t'(2));
        else
            nextElim = idx_t'(rowPtr + idx_t'(1));
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= stIdle;
            col <= '0;
            rowPtr <= '0;
        end
        else
        begin
            case (state)
                stIdle:
                begin
                    if (start)
                        state <= stFill;
                end
                stFill:
                begin
                    col <= '0;
                    rowPtr <= '0;
                    state <= stSearch;
                end
                stSearch:
                begin
                    if (searchElem != '0)
                    begin
                        // rowPtr keeps the found row for the swap
                        if (rowPtr != col)
                        begin
                            state <= stSwap;
                        end
                        else
                        begin
                            rowPtr <= firstRow;
                            state <= stEliminate;
                        end
                    end
                    else if (rowPtr == lastRow)
                    begin
                        state <= stSingular;
                    end
                    else
                    begin
                        rowPtr <= rowPtr + idx_t'(1);
                    end
                end
                stSwap:
                begin
                    rowPtr <= firstRow;
                    state <= stEliminate;
                end
                stEliminate:
                begin
                    if (nextElim > lastRow)
                        state <= stNextCol;
                    else
                        rowPtr <= nextElim;
                end
                stNextCol:
                begin
                    if (col == lastRow)
                    begin
                        state <= stDone;
                    end
                    else
                    begin
                        // Search restarts at the diagonal of the next column
                        col <= col + idx_t'(1);
                        rowPtr <= col + idx_t'(1);
                        state <= stSearch;
                    end
                end
                stDone:
                begin
                    state <= stIdle;
                end
                stSingular:
                begin
                    state <= stIdle;
                end
                default:
                begin
                    state <= stIdle;
                end
            endcase
        end
    end

    assign fillEn = (state == stFill);
    assign swapEn = (state == stSwap);
    assign writeEn = (state == stEliminate);
    assign swapA = col;
    assign swapB = rowPtr;
    assign targetRow = rowPtr;
    assign pivotRow = col;
    assign pivotCol = col;
    assign busy = (state != stIdle);
    assign finished = (state == stDone) || (state == stSingular);
    assign singular = (state == stSingular);

    // Search and swap leave a nonzero pivot on the diagonal
    pivotNonZero: assert property (@(posedge clk) disable iff (rst)
        writeEn |-> pivotElem != '0)
        else $error("elimination with a zero pivot");

endmodule

/* rowEliminate.sv */
`timescale 1ns/1ps

module rowEliminate import gjPkg::*;
#(
    parameter int matrixSize = 4
)
(
    input  logic [2*matrixSize*elemWidth-1:0] targetVec,
    input  logic [2*matrixSize*elemWidth-1:0] pivotVec,
    input  idx_t                              pivotCol,
    output logic [2*matrixSize*elemWidth-1:0] newRow,
    output logic                              skip
);

    localparam int augWidth = 2 * matrixSize;

    elem_t factor;
    elem_t pivot;

    // Pick the pivot and the target's factor out of the pivot column
    always_comb
    begin
        factor = '0;
        pivot = '0;
        for (int c = 0; c < augWidth; c++)
        begin
            if (idx_t'(c) == pivotCol)
            begin
                factor = targetVec[c*elemWidth +: elemWidth];
                pivot = pivotVec[c*elemWidth +: elemWidth];
            end
        end
    end

    // Row already clear in this column
    assign skip = (factor == '0);

    // Cross multiply, target times pivot minus pivot row times factor
    for (genvar j = 0; j < augWidth; j++)
    begin : gCol
        elem_t targetElem;
        elem_t pivotRowElem;

        assign targetElem = targetVec[j*elemWidth +: elemWidth];
        assign pivotRowElem = pivotVec[j*elemWidth +: elemWidth];
        assign newRow[j*elemWidth +: elemWidth] = targetElem * pivot - pivotRowElem * factor;
    end

endmodule

/* resultPort.sv */
`timescale 1ns/1ps

module resultPort import gjPkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  req,
    input  logic  finished,
    input  logic  singularIn,
    input  elem_t rdElem,
    output logic  ack,
    output logic  singular,
    output logic  start,
    output elem_t rdData
);

    logic reqDly;

    // Rising req starts a run
    assign start = req && !reqDly;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            reqDly <= 1'b0;
            ack <= 1'b0;
            singular <= 1'b0;
        end
        else
        begin
            reqDly <= req;
            if (finished)
            begin
                ack <= 1'b1;
                singular <= singularIn;
            end
            else if (ack && !req)
            begin
                // Host released req so close the handshake
                ack <= 1'b0;
                singular <= 1'b0;
            end
        end
    end

    // Readout register
    always_ff @(posedge clk)
    begin
        rdData <= rdElem;
    end

    // Host may only drop req once the engine has answered
    reqHeldUntilAck: assert property (@(posedge clk) disable iff (rst)
        (reqDly && !req) |-> ack)
        else $error("req dropped before ack");

endmodule

/* matrixInverse.sv */
`timescale 1ns/1ps

module matrixInverse import gjPkg::*;
#(
    parameter int matrixSize = 4
)
(
    input  logic  clk,
    input  logic  rst,
    input  logic  wrEn,
    input  idx_t  wrRow,
    input  idx_t  wrCol,
    input  elem_t wrData,
    input  logic  req,
    output logic  ack,
    output logic  singular,
    input  idx_t  rdRow,
    input  idx_t  rdCol,
    output elem_t rdData
);

    localparam int rowBits = 2 * matrixSize * elemWidth;

    logic               start;
    logic               finished;
    logic               decSingular;
    logic               busy;
    logic               fillEn;
    logic               swapEn;
    idx_t               swapA;
    idx_t               swapB;
    logic               writeEn;
    idx_t               targetRow;
    idx_t               pivotRow;
    idx_t               pivotCol;
    logic [rowBits-1:0] targetVec;
    logic [rowBits-1:0] pivotVec;
    logic [rowBits-1:0] newRow;
    logic               skip;
    elem_t              searchElem;
    elem_t              pivotElem;
    elem_t              rdElem;

    matrixStore #(
        .matrixSize(matrixSize)
    ) store (
        .clk(clk),
        .rst(rst),
        .busy(busy),
        .wrEn(wrEn),
        .wrRow(wrRow),
        .wrCol(wrCol),
        .wrData(wrData),
        .fillEn(fillEn),
        .swapEn(swapEn),
        .swapA(swapA),
        .swapB(swapB),
        .writeEn(writeEn),
        .targetRow(targetRow),
        .pivotRow(pivotRow),
        .pivotCol(pivotCol),
        .newRow(newRow),
        .skip(skip),
        .rdRow(rdRow),
        .rdCol(rdCol),
        .targetVec(targetVec),
        .pivotVec(pivotVec),
        .searchElem(searchElem),
        .pivotElem(pivotElem),
        .rdElem(rdElem)
    );

    pivotDecode #(
        .matrixSize(matrixSize)
    ) decode (
        .clk(clk),
        .rst(rst),
        .start(start),
        .searchElem(searchElem),
        .pivotElem(pivotElem),
        .fillEn(fillEn),
        .swapEn(swapEn),
        .swapA(swapA),
        .swapB(swapB),
        .writeEn(writeEn),
        .targetRow(targetRow),
        .pivotRow(pivotRow),
        .pivotCol(pivotCol),
        .busy(busy),
        .finished(finished),
        .singular(decSingular)
    );

    rowEliminate #(
        .matrixSize(matrixSize)
    ) execute (
        .targetVec(targetVec),
        .pivotVec(pivotVec),
        .pivotCol(pivotCol),
        .newRow(newRow),
        .skip(skip)
    );

    resultPort result (
        .clk(clk),
        .rst(rst),
        .req(req),
        .finished(finished),
        .singularIn(decSingular),
        .rdElem(rdElem),
        .ack(ack),
        .singular(singular),
        .start(start),
        .rdData(rdData)
    );

endmodule

/* tbMatrixInverse.sv */
`timescale 1ns/1ps

module tbMatrixInverse import gjPkg::*;
();

    localparam int n = 4;
    localparam int augWidth = 2 * n;
    localparam int clkPeriod = 10;
    localparam int numTests = 16;
    localparam int ackLimit = n * n + 4 * n + 50;
    // Loading, run, two-cycle readouts and the handshake hold
    localparam int cyclesPerTest = 8 * n * n + 8 * n + 50;
    localparam int timeoutCycles = numTests * cyclesPerTest + 100;

    typedef elem_t sqMat_t [n][n];
    typedef elem_t augMat_t [n][augWidth];

    logic  clk = 1'b0;
    logic  rst;
    logic  wrEn;
    idx_t  wrRow;
    idx_t  wrCol;
    elem_t wrData;
    logic  req;
    logic  ack;
    logic  singular;
    idx_t  rdRow;
    idx_t  rdCol;
    elem_t rdData;

    int      seed = 8977;
    int      errorCount = 0;
    int      checkCount = 0;
    int      testCount = 0;
    augMat_t got;
    logic    gotSingular;
    logic    expSingular;

    matrixInverse #(
        .matrixSize(n)
    ) uut (
        .clk(clk),
        .rst(rst),
        .wrEn(wrEn),
        .wrRow(wrRow),
        .wrCol(wrCol),
        .wrData(wrData),
        .req(req),
        .ack(ack),
        .singular(singular),
        .rdRow(rdRow),
        .rdCol(rdCol),
        .rdData(rdData)
    );

    always #(clkPeriod / 2) clk = ~clk;

    // Column by column elimination that stops at the first column without a pivot
    function automatic logic refReduce(input sqMat_t a, output augMat_t m);
        int    p;
        elem_t pv;
        elem_t f;
        elem_t t;
        for (int r = 0; r < n; r++)
        begin
            for (int c = 0; c < augWidth; c++)
            begin
                if (c < n)
                    m[r][c] = a[r][c];
                else
                    m[r][c] = (c - n == r) ? elem_t'(1) : elem_t'(0);
            end
        end
        for (int col = 0; col < n; col++)
        begin
            p = -1;
            for (int r = col; r < n; r++)
            begin
                if (p < 0 && m[r][col] != 0)
                    p = r;
            end
            if (p < 0)
                return 1'b1;
            if (p != col)
            begin
                for (int c = 0; c < augWidth; c++)
                begin
                    t = m[col][c];
                    m[col][c] = m[p][c];
                    m[p][c] = t;
                end
            end
            pv = m[col][col];
            for (int r = 0; r < n; r++)
            begin
                if (r != col && m[r][col] != 0)
                begin
                    f = m[r][col];
                    for (int c = 0; c < augWidth; c++)
                        m[r][c] = m[r][c] * pv - m[col][c] * f;
                end
            end
        end
        return 1'b0;
    endfunction

    task automatic checkElem(input string name, input int r, input int c,
                             input elem_t value, input elem_t want);
        checkCount++;
        if (value !== want)
        begin
            errorCount++;
            $display("[ERROR] %s[%0d][%0d] got %h expected %h at %0t",
                     name, r, c, value, want, $time);
        end
    endtask

    task automatic checkFlag(input string name, input logic value, input logic want);
        checkCount++;
        if (value !== want)
        begin
            errorCount++;
            $display("[ERROR] %s got %h expected %h at %0t", name, value, want, $time);
        end
    endtask

    task automatic randomMatrix(output sqMat_t a);
        for (int r = 0; r < n; r++)
        begin
            for (int c = 0; c < n; c++)
                a[r][c] = $random(seed) % 4;
        end
    endtask

    task automatic loadMatrix(input sqMat_t a);
        for (int r = 0; r < n; r++)
        begin
            for (int c = 0; c < n; c++)
            begin
                @(negedge clk);
                wrEn = 1'b1;
                wrRow = idx_t'(r);
                wrCol = idx_t'(c);
                wrData = a[r][c];
            end
        end
        @(negedge clk);
        wrEn = 1'b0;
    endtask

    task automatic readElem(input int r, input int c, output elem_t v);
        @(negedge clk);
        rdRow = idx_t'(r);
        rdCol = idx_t'(c);
        @(negedge clk);
        v = rdData;
    endtask

    // Load, handshake, read back and compare one matrix
    task automatic runTest(input string label, input sqMat_t a, input logic corrupt);
        augMat_t expected;
        elem_t   v;
        elem_t   acc;
        int      waitCycles;
        int      hold;
        expSingular = refReduce(a, expected);
        testCount++;
        loadMatrix(a);
        @(negedge clk);
        req = 1'b1;
        if (corrupt)
        begin
            // These land while the engine is busy and must be dropped
            @(negedge clk);
            @(negedge clk);
            wrEn = 1'b1;
            wrRow = idx_t'(0);
            wrCol = idx_t'(0);
            wrData = elem_t'(32'h5a5a_0001);
            @(negedge clk);
            wrRow = idx_t'(n - 1);
            wrCol = idx_t'(n - 1);
            @(negedge clk);
            wrEn = 1'b0;
        end
        waitCycles = 0;
        while (ack !== 1'b1 && waitCycles < ackLimit)
        begin
            @(negedge clk);
            waitCycles++;
        end
        if (ack !== 1'b1)
        begin
            errorCount++;
            $display("%s: no ack within %0d cycles of req", label, ackLimit);
        end
        gotSingular = singular;
        checkFlag({label, " singular"}, singular, expSingular);
        for (int r = 0; r < n; r++)
        begin
            for (int c = 0; c < augWidth; c++)
            begin
                readElem(r, c, v);
                got[r][c] = v;
                checkElem({label, " elem"}, r, c, v, expected[r][c]);
            end
        end
        // Right half times the input equals the left half
        for (int r = 0; r < n; r++)
        begin
            for (int c = 0; c < n; c++)
            begin
                acc = '0;
                for (int k = 0; k < n; k++)
                    acc = acc + got[r][n + k] * a[k][c];
                checkElem({label, " rightTimesInput"}, r, c, acc, expected[r][c]);
            end
        end
        hold = 1 + ($unsigned($random(seed)) % 8);
        repeat (hold)
        begin
            @(negedge clk);
            checkFlag({label, " ack held"}, ack, 1'b1);
            checkElem({label, " rdData held"}, n - 1, augWidth - 1, rdData,
                      expected[n - 1][augWidth - 1]);
        end
        req = 1'b0;
        @(negedge clk);
        checkFlag({label, " ack release"}, ack, 1'b0);
    endtask

    initial
    begin
        sqMat_t a;
        rst = 1'b1;
        wrEn = 1'b0;
        wrRow = '0;
        wrCol = '0;
        wrData = '0;
        req = 1'b0;
        rdRow = '0;
        rdCol = '0;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        checkFlag("ack after reset", ack, 1'b0);
        checkFlag("singular after reset", singular, 1'b0);

        for (int r = 0; r < n; r++)
        begin
            for (int c = 0; c < n; c++)
                a[r][c] = (r == c) ? elem_t'(1) : elem_t'(0);
        end
        runTest("identity", a, 1'b0);
        for (int r = 0; r < n; r++)
        begin
            for (int c = 0; c < augWidth; c++)
                checkElem("identity result", r, c, got[r][c],
                          (c == r || c == r + n) ? elem_t'(1) : elem_t'(0));
        end
        checkFlag("identity singular", gotSingular, 1'b0);

        // Zero at the first pivot forces a row exchange
        randomMatrix(a);
        a[0][0] = '0;
        a[1][0] = elem_t'(1);
        runTest("swap", a, 1'b0);

        for (int t = 0; t < numTests - 4; t++)
        begin
            randomMatrix(a);
            runTest("random", a, t == 5);
            if (!expSingular)
            begin
                for (int r = 0; r < n; r++)
                begin
                    for (int c = 0; c < n; c++)
                    begin
                        if (r != c)
                            checkElem("random offDiagonal", r, c, got[r][c], '0);
                    end
                end
            end
        end

        // Row 1 goes to zero in column 0 and never supplies a pivot
        randomMatrix(a);
        if (a[0][0] == 0)
            a[0][0] = elem_t'(1);
        for (int c = 0; c < n; c++)
            a[1][c] = a[0][c];
        runTest("equal rows", a, 1'b0);
        checkFlag("equal rows singular", gotSingular, 1'b1);

        randomMatrix(a);
        for (int r = 0; r < n; r++)
            a[r][n - 2] = '0;
        runTest("zero column", a, 1'b0);
        checkFlag("zero column singular", gotSingular, 1'b1);

        $display("Tests: %0d, checks: %0d, errors: %0d", testCount, checkCount, errorCount);
        if (errorCount == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

    // Watchdog
    initial
    begin
        gjState_t st;
        #(timeoutCycles * clkPeriod);
        st = uut.decode.state;
        $display("Timeout after %0d cycles in test %0d, sequencer state %s",
                 timeoutCycles, testCount, st.name());
        $display("Test failed");
        $finish;
    end

endmodule

/* filelist.f */
gjPkg.sv
matrixStore.sv
pivotDecode.sv
rowEliminate.sv
resultPort.sv
matrixInverse.sv
tbMatrixInverse.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tbMatrixInverse
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing
PASS_MSG  ?= Test passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
